// ==== rtl/ironhorse_params.svh ====
// Constants for the Iron Horse cabinet glue logic
// Key codes are PS/2 set 2 make codes without the extended prefix
// PLL counter words target the Cyclone V reconfiguration block
`ifndef IRONHORSE_PARAMS_SVH
`define IRONHORSE_PARAMS_SVH

// ==============================
// Keyboard scan codes
// ==============================
`define IH_KEY_START1    8'h16
`define IH_KEY_START2    8'h1E
`define IH_KEY_COIN1     8'h2E
`define IH_KEY_COIN2     8'h36
`define IH_KEY_SERVICE   8'h46
`define IH_KEY_UP        8'h75
`define IH_KEY_DOWN      8'h72
`define IH_KEY_LEFT      8'h6B
`define IH_KEY_RIGHT     8'h74
`define IH_KEY_B1        8'h14
`define IH_KEY_B2        8'h11
`define IH_KEY_B3        8'h29

// ==============================
// Download stream and video
// ==============================
`define IH_IDX_HEADER    8'd1
`define IH_IDX_DIP       8'd254
`define IH_DIP_BYTES     3
`define IH_PIX_DIV       8

// ==============================
// PLL reconfiguration port
// ==============================
`define IH_PLL_ADDR_MODE   6'd0
`define IH_PLL_ADDR_M      6'd7
`define IH_PLL_ADDR_START  6'd2
`define IH_PLL_M_NATIVE    32'd3639383488
`define IH_PLL_M_60HZ      32'd2971430088
`define IH_PLL_M_BOOTLEG   32'd2748778984
`define IH_BOOTLEG_RECONF  2'b10

`endif

// ==== rtl/ironhorse_pkg.sv ====
// Shared packed types for the cabinet glue logic
// Cabinet and player controls are active low, keyboard and joystick active high
`include "ironhorse_params.svh"

package ironhorse_pkg;

	// Key event as delivered by the host, new event on toggle change
	typedef struct packed {
		logic       toggle;
		logic       pressed;
		logic       extended;
		logic [7:0] code;
	} key_event_t;

	// Held keyboard buttons
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic b1;
		logic b2;
		logic b3;
		logic coin1;
		logic coin2;
		logic start1;
		logic start2;
		logic service;
	} kb_buttons_t;

	// Raw joystick word, bit 0 is right
	typedef struct packed {
		logic [5:0] reserved;
		logic       start2;
		logic       coin1;
		logic       start1;
		logic       b3;
		logic       b2;
		logic       b1;
		logic       up;
		logic       down;
		logic       left;
		logic       right;
	} joy_t;

	// Buttons are {b3, b2, b1}, joystick is {down, up, right, left}
	typedef struct packed {
		logic [2:0] buttons;
		logic [3:0] joystick;
	} player_ctrl_t;

	typedef struct packed {
		player_ctrl_t p1;
		player_ctrl_t p2;
		logic [1:0]   coin;
		logic [1:0]   start;
		logic         service;
	} cabinet_ctrl_t;

	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [24:0] addr;
		logic [7:0]  data;
	} dl_stream_t;

	typedef struct packed {
		logic [1:0] is_bootleg;
		logic       is_japan;
	} board_cfg_t;

	// Byte 0 in the low bits
	typedef struct packed {
		logic [`IH_DIP_BYTES-1:0][7:0] sw;
	} dipsw_t;

	typedef struct packed {
		logic        write;
		logic [5:0]  address;
		logic [31:0] data;
	} pll_mgmt_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb4_t;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb8_t;

endpackage

// ==== rtl/key_decoder.sv ====
// Held-key decoder for host key events
// Extended prefix is ignored, so keypad and arrow codes alias
`timescale 1ns/1ps
`include "ironhorse_params.svh"

module key_decoder (
	input  logic                      CLK_49M,
	input  logic                      reset,
	input  ironhorse_pkg::key_event_t key_event,
	output ironhorse_pkg::kb_buttons_t buttons
);

	// Last toggle level seen
	logic toggle_q;

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			// Take current level as baseline, no spurious event
			toggle_q <= key_event.toggle;
			buttons  <= '0;
		end else begin
			toggle_q <= key_event.toggle;
			if (toggle_q != key_event.toggle) begin
				case (key_event.code)
					// Cabinet keys
					`IH_KEY_START1:  buttons.start1  <= key_event.pressed;
					`IH_KEY_START2:  buttons.start2  <= key_event.pressed;
					`IH_KEY_COIN1:   buttons.coin1   <= key_event.pressed;
					`IH_KEY_COIN2:   buttons.coin2   <= key_event.pressed;
					`IH_KEY_SERVICE: buttons.service <= key_event.pressed;
					// Directions
					`IH_KEY_UP:      buttons.up      <= key_event.pressed;
					`IH_KEY_DOWN:    buttons.down    <= key_event.pressed;
					`IH_KEY_LEFT:    buttons.left    <= key_event.pressed;
					`IH_KEY_RIGHT:   buttons.right   <= key_event.pressed;
					// Fire buttons
					`IH_KEY_B1:      buttons.b1      <= key_event.pressed;
					`IH_KEY_B2:      buttons.b2      <= key_event.pressed;
					`IH_KEY_B3:      buttons.b3      <= key_event.pressed;
					// Unknown codes leave state alone
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== rtl/control_mixer.sv ====
// Keyboard and joystick merge into active-low cabinet controls
// Keyboard drives both players at once
// Japanese board swaps button 3 between the two joysticks
`timescale 1ns/1ps

module control_mixer (
	input  logic                         CLK_49M,
	input  logic                         reset,
	input  ironhorse_pkg::kb_buttons_t   kb,
	input  ironhorse_pkg::joy_t          joy0,
	input  ironhorse_pkg::joy_t          joy1,
	input  ironhorse_pkg::board_cfg_t    board,
	output ironhorse_pkg::cabinet_ctrl_t cabinet
);

	ironhorse_pkg::cabinet_ctrl_t cab_next;

	// One player, b3_joy picked by the caller for the swap
	function automatic ironhorse_pkg::player_ctrl_t mix_player(
		input ironhorse_pkg::kb_buttons_t k,
		input ironhorse_pkg::joy_t        j,
		input logic                       b3_joy
	);
		ironhorse_pkg::player_ctrl_t p;
		p.buttons  = ~{k.b3 | b3_joy, k.b2 | j.b2, k.b1 | j.b1};
		p.joystick = ~{k.down | j.down, k.up | j.up, k.right | j.right, k.left | j.left};
		return p;
	endfunction

	always_comb begin
		cab_next.p1 = mix_player(kb, joy0, board.is_japan ? joy1.b3 : joy0.b3);
		cab_next.p2 = mix_player(kb, joy1, board.is_japan ? joy0.b3 : joy1.b3);
		// Coin 2 is keyboard only
		cab_next.coin  = ~{kb.coin2, kb.coin1 | joy0.coin1 | joy1.coin1};
		cab_next.start = ~{kb.start2 | joy0.start2 | joy1.start2,
		                   kb.start1 | joy0.start1 | joy1.start1};
		// No joystick mapping for service
		cab_next.service = ~kb.service;
	end

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			// All released
			cabinet <= '1;
		end else begin
			cabinet <= cab_next;
		end
	end

endmodule

// ==== rtl/config_loader.sv ====
// Board-variant flags and DIP bytes taken from the download stream
// Header byte is only the one at address 0 of its index
// DIP bytes are kept as loaded, inversion is up to the core
`timescale 1ns/1ps
`include "ironhorse_params.svh"

module config_loader (
	input  logic                      CLK_49M,
	input  logic                      reset,
	input  ironhorse_pkg::dl_stream_t dl,
	output ironhorse_pkg::board_cfg_t board,
	output ironhorse_pkg::dipsw_t     dipsw
);

	logic hdr_wr;
	logic dip_wr;

	// Only bytes with the strobe count
	assign hdr_wr = dl.wr && (dl.index == `IH_IDX_HEADER) && (dl.addr == '0);
	assign dip_wr = dl.wr && (dl.index == `IH_IDX_DIP);

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			board <= '0;
			dipsw <= '0;
		end else begin
			if (hdr_wr) begin
				board.is_bootleg <= dl.data[1:0];
				board.is_japan   <= dl.data[4];
			end
			// Addresses past the last DIP byte drop out here
			if (dip_wr) begin
				for (int i = 0; i < `IH_DIP_BYTES; i++) begin
					if (dl.addr == 25'(i))
						dipsw.sw[i] <= dl.data;
				end
			end
		end
	end

endmodule

// ==== rtl/pll_reconfig_seq.sv ====
// PLL reconfiguration write sequencer, Avalon-style write with wait-request
// Options must hold for two samples before a sequence starts
// All outputs freeze while waitrequest is high
`timescale 1ns/1ps
`include "ironhorse_params.svh"

module pll_reconfig_seq (
	input  logic                     CLK_49M,
	input  logic                     reset,
	input  logic                     underclock,
	input  logic [1:0]               is_bootleg,
	input  logic                     waitrequest,
	output ironhorse_pkg::pll_mgmt_t mgmt
);

	// Write currently presented on the port
	typedef enum logic [1:0] {ST_IDLE, ST_MODE, ST_M, ST_START} step_t;

	step_t      step;
	logic       bl_now;
	logic       uc_s1, uc_s2, uc_cur;
	logic       bl_s1, bl_s2, bl_cur;
	logic       uc_chg, bl_chg;
	logic       restart;
	logic [31:0] m_word;

	assign bl_now = (is_bootleg == `IH_BOOTLEG_RECONF);

	// Stable for two samples and differs from the applied copy
	assign uc_chg = (uc_s1 == uc_s2) && (uc_s2 != uc_cur);
	assign bl_chg = (bl_s1 == bl_s2) && (bl_s2 != bl_cur);

	// Bootleg wins over the 60 Hz adjust
	assign m_word = bl_cur ? `IH_PLL_M_BOOTLEG :
	                uc_cur ? `IH_PLL_M_60HZ : `IH_PLL_M_NATIVE;

	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			// Options at reset release are the baseline
			uc_s1   <= underclock;
			uc_s2   <= underclock;
			uc_cur  <= underclock;
			bl_s1   <= bl_now;
			bl_s2   <= bl_now;
			bl_cur  <= bl_now;
			restart <= 1'b0;
			step    <= ST_IDLE;
			mgmt    <= '0;
		end else begin
			uc_s1 <= underclock;
			uc_s2 <= uc_s1;
			bl_s1 <= bl_now;
			bl_s2 <= bl_s1;
			if (uc_chg)
				uc_cur <= uc_s2;
			if (bl_chg)
				bl_cur <= bl_s2;

			if (waitrequest) begin
				// Port frozen, remember the change for later
				if (uc_chg || bl_chg)
					restart <= 1'b1;
			end else if (uc_chg || bl_chg || restart) begin
				restart <= 1'b0;
				step    <= ST_MODE;
				mgmt    <= '{write: 1'b1, address: `IH_PLL_ADDR_MODE, data: '0};
			end else begin
				// A busy step here means its write was just accepted
				case (step)
					ST_MODE: begin
						step <= ST_M;
						mgmt <= '{write: 1'b1, address: `IH_PLL_ADDR_M, data: m_word};
					end
					ST_M: begin
						step <= ST_START;
						mgmt <= '{write: 1'b1, address: `IH_PLL_ADDR_START, data: '0};
					end
					default: begin
						step       <= ST_IDLE;
						mgmt.write <= 1'b0;
					end
				endcase
			end
		end
	end

endmodule

// ==== rtl/video_color.sv ====
// Resistor-DAC colour lookup and pixel clock enable
// Table values are measured on the original PCB
`timescale 1ns/1ps
`include "ironhorse_params.svh"

module video_color (
	input  logic                 CLK_49M,
	input  logic                 reset,
	input  ironhorse_pkg::rgb4_t rgb_in,
	output ironhorse_pkg::rgb8_t rgb_out,
	output logic                 ce_pix
);

	localparam int DIV_W = $clog2(`IH_PIX_DIV);

	// 4-bit level to 8-bit intensity
	localparam logic [7:0] DAC_TABLE [16] = '{
		8'd0,   8'd14,  8'd31,  8'd46,
		8'd67,  8'd81,  8'd98,  8'd112,
		8'd143, 8'd157, 8'd174, 8'd188,
		8'd209, 8'd224, 8'd241, 8'd255
	};

	logic [DIV_W-1:0] div;

	// Colour path
	always_ff @(posedge CLK_49M) begin
		rgb_out.r <= DAC_TABLE[rgb_in.r];
		rgb_out.g <= DAC_TABLE[rgb_in.g];
		rgb_out.b <= DAC_TABLE[rgb_in.b];
	end

	// One enable per divider period
	always_ff @(posedge CLK_49M) begin
		if (reset) begin
			div    <= '0;
			ce_pix <= 1'b0;
		end else begin
			div    <= (div == DIV_W'(`IH_PIX_DIV - 1)) ? '0 : div + 1'b1;
			ce_pix <= (div == '0);
		end
	end

endmodule

// ==== rtl/ironhorse_glue.sv ====
// Cabinet glue top level for the Iron Horse core wrapper
// Single clock domain, synchronous active-high reset
`timescale 1ns/1ps

module ironhorse_glue (
	input  logic                         CLK_49M,
	input  logic                         reset,
	input  ironhorse_pkg::key_event_t    key_event,
	input  ironhorse_pkg::joy_t          joy0,
	input  ironhorse_pkg::joy_t          joy1,
	input  ironhorse_pkg::dl_stream_t    dl,
	input  logic                         underclock,
	input  ironhorse_pkg::rgb4_t         rgb_in,
	input  logic                         pll_waitrequest,
	output ironhorse_pkg::cabinet_ctrl_t cabinet,
	output ironhorse_pkg::dipsw_t        dipsw,
	output ironhorse_pkg::board_cfg_t    board,
	output ironhorse_pkg::rgb8_t         rgb_out,
	output logic                         ce_pix,
	output ironhorse_pkg::pll_mgmt_t     pll_mgmt
);

	ironhorse_pkg::kb_buttons_t kb_buttons;

	// ==============================
	// Controls
	// ==============================
	key_decoder key_decoder_i (
		.CLK_49M   (CLK_49M),
		.reset     (reset),
		.key_event (key_event),
		.buttons   (kb_buttons)
	);

	control_mixer control_mixer_i (
		.CLK_49M (CLK_49M),
		.reset   (reset),
		.kb      (kb_buttons),
		.joy0    (joy0),
		.joy1    (joy1),
		.board   (board),
		.cabinet (cabinet)
	);

	// ==============================
	// Configuration and clocks
	// ==============================
	config_loader config_loader_i (
		.CLK_49M (CLK_49M),
		.reset   (reset),
		.dl      (dl),
		.board   (board),
		.dipsw   (dipsw)
	);

	pll_reconfig_seq pll_reconfig_seq_i (
		.CLK_49M     (CLK_49M),
		.reset       (reset),
		.underclock  (underclock),
		.is_bootleg  (board.is_bootleg),
		.waitrequest (pll_waitrequest),
		.mgmt        (pll_mgmt)
	);

	// Video
	video_color video_color_i (
		.CLK_49M (CLK_49M),
		.reset   (reset),
		.rgb_in  (rgb_in),
		.rgb_out (rgb_out),
		.ce_pix  (ce_pix)
	);

endmodule

// ==== sim/ironhorse_assertions.sv ====
// Concurrent checks bound into the glue top level
// Port names follow the top-level ports
`timescale 1ns/1ps

module ironhorse_assertions (
	input logic                         CLK_49M,
	input logic                         reset,
	input logic                         ce_pix,
	input ironhorse_pkg::cabinet_ctrl_t cabinet,
	input ironhorse_pkg::pll_mgmt_t     pll_mgmt,
	input logic                         pll_waitrequest
);

	int fail_count = 0;

	// Pixel enable is a single-cycle pulse
	ce_pix_single: assert property (@(posedge CLK_49M) disable iff (reset)
		ce_pix |=> !ce_pix)
		else begin
			fail_count++;
			$error("ce_pix high two cycles in a row");
		end

	// Port frozen under back-pressure
	pll_hold: assert property (@(posedge CLK_49M) disable iff (reset)
		pll_waitrequest |=> $stable(pll_mgmt))
		else begin
			fail_count++;
			$error("PLL write changed while waitrequest was high");
		end

	// First registered controls after reset release are all released
	cabinet_idle: assert property (@(posedge CLK_49M)
		$fell(reset) |=> (cabinet == '1))
		else begin
			fail_count++;
			$error("cabinet not all ones after reset");
		end

endmodule

// ==== sim/tb_ironhorse_glue.sv ====
// Testbench for the Iron Horse cabinet glue top level
// Stops at the first error, a watchdog bounds the run length
// Needs concurrent assertion and bind support in the simulator
`timescale 1ns/1ps
`include "ironhorse_params.svh"

module tb_ironhorse_glue;

	localparam int N_KEY = 60;
	localparam int N_JOY = 40;
	localparam int N_DL  = 40;
	localparam int N_RGB = 40;
	localparam int N_PLL = 5;
	localparam int N_VECTORS = N_KEY + 12 + 2 * N_JOY + N_DL + N_RGB + N_PLL;
	localparam int WATCHDOG_CYCLES = N_VECTORS * 20 + 2000;

	// Same order as the held-key vector, MSB first
	localparam logic [7:0] KEY_CODES [12] = '{
		`IH_KEY_UP, `IH_KEY_DOWN, `IH_KEY_LEFT, `IH_KEY_RIGHT,
		`IH_KEY_B1, `IH_KEY_B2, `IH_KEY_B3, `IH_KEY_COIN1,
		`IH_KEY_COIN2, `IH_KEY_START1, `IH_KEY_START2, `IH_KEY_SERVICE
	};
	// Measured resistor-DAC levels
	localparam logic [7:0] DAC_REF [16] = '{
		8'd0, 8'd14, 8'd31, 8'd46, 8'd67, 8'd81, 8'd98, 8'd112,
		8'd143, 8'd157, 8'd174, 8'd188, 8'd209, 8'd224, 8'd241, 8'd255
	};

	logic                         CLK_49M;
	logic                         reset;
	ironhorse_pkg::key_event_t    key_event;
	ironhorse_pkg::joy_t          joy0;
	ironhorse_pkg::joy_t          joy1;
	ironhorse_pkg::dl_stream_t    dl;
	logic                         underclock;
	ironhorse_pkg::rgb4_t         rgb_in;
	logic                         pll_waitrequest;
	ironhorse_pkg::cabinet_ctrl_t cabinet;
	ironhorse_pkg::dipsw_t        dipsw;
	ironhorse_pkg::board_cfg_t    board;
	ironhorse_pkg::rgb8_t         rgb_out;
	logic                         ce_pix;
	ironhorse_pkg::pll_mgmt_t     pll_mgmt;

	integer                     seed = 32'had60;
	ironhorse_pkg::kb_buttons_t kb_ref;
	ironhorse_pkg::board_cfg_t  board_ref;
	ironhorse_pkg::dipsw_t      dip_ref;
	ironhorse_pkg::pll_mgmt_t   pll_seen [$];

	ironhorse_glue ironhorse_glue_i (.*);

	bind ironhorse_glue ironhorse_assertions ironhorse_assertions_i (
		.CLK_49M         (CLK_49M),
		.reset           (reset),
		.ce_pix          (ce_pix),
		.cabinet         (cabinet),
		.pll_mgmt        (pll_mgmt),
		.pll_waitrequest (pll_waitrequest)
	);

	always #5 CLK_49M = ~CLK_49M;

	// ==============================
	// Reference model
	// ==============================
	function automatic ironhorse_pkg::kb_buttons_t kb_after_event(
		input ironhorse_pkg::kb_buttons_t k, input logic [7:0] code, input logic pressed);
		ironhorse_pkg::kb_buttons_t n;
		n = k;
		for (int i = 0; i < 12; i++) begin
			if (code == KEY_CODES[i])
				n[11-i] = pressed;
		end
		return n;
	endfunction

	// Raw joystick bit positions, not the struct fields
	function automatic ironhorse_pkg::player_ctrl_t expected_player(
		input ironhorse_pkg::kb_buttons_t k, input logic [15:0] j, input logic b3);
		ironhorse_pkg::player_ctrl_t p;
		p.buttons  = ~{k.b3 | b3, k.b2 | j[5], k.b1 | j[4]};
		p.joystick = ~{k.down | j[2], k.up | j[3], k.right | j[0], k.left | j[1]};
		return p;
	endfunction

	function automatic ironhorse_pkg::cabinet_ctrl_t expected_cabinet(
		input ironhorse_pkg::kb_buttons_t k, input logic [15:0] j0, input logic [15:0] j1,
		input logic japan);
		ironhorse_pkg::cabinet_ctrl_t c;
		// Japanese board crosses button 3
		c.p1      = expected_player(k, j0, japan ? j1[6] : j0[6]);
		c.p2      = expected_player(k, j1, japan ? j0[6] : j1[6]);
		c.coin    = ~{k.coin2, k.coin1 | j0[8] | j1[8]};
		c.start   = ~{k.start2 | j0[9] | j1[9], k.start1 | j0[7] | j1[7]};
		c.service = ~k.service;
		return c;
	endfunction

	function automatic ironhorse_pkg::rgb8_t expected_rgb(input ironhorse_pkg::rgb4_t c);
		ironhorse_pkg::rgb8_t o;
		o.r = DAC_REF[c.r];
		o.g = DAC_REF[c.g];
		o.b = DAC_REF[c.b];
		return o;
	endfunction

	function automatic ironhorse_pkg::pll_mgmt_t expected_pll_write(
		input int idx, input logic bootleg, input logic uc);
		ironhorse_pkg::pll_mgmt_t w;
		w.write = 1'b1;
		w.data  = '0;
		case (idx)
			0: w.address = `IH_PLL_ADDR_MODE;
			1: begin
				w.address = `IH_PLL_ADDR_M;
				if (bootleg)
					w.data = `IH_PLL_M_BOOTLEG;
				else if (uc)
					w.data = `IH_PLL_M_60HZ;
				else
					w.data = `IH_PLL_M_NATIVE;
			end
			default: w.address = `IH_PLL_ADDR_START;
		endcase
		return w;
	endfunction

	task automatic apply_dl_ref(input ironhorse_pkg::dl_stream_t d);
		if (d.wr && d.index == `IH_IDX_HEADER && d.addr == '0) begin
			board_ref.is_bootleg = d.data[1:0];
			board_ref.is_japan   = d.data[4];
		end
		if (d.wr && d.index == `IH_IDX_DIP && d.addr < `IH_DIP_BYTES)
			dip_ref[int'(d.addr) * 8 +: 8] = d.data;
	endtask

	// ==============================
	// Compare
	// ==============================
	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "Run stopped at first error");
	endtask

	task automatic check_cabinet(input string name, input ironhorse_pkg::cabinet_ctrl_t exp,
		input ironhorse_pkg::cabinet_ctrl_t act);
		if (act !== exp)
			stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_rgb(input string name, input ironhorse_pkg::rgb8_t exp,
		input ironhorse_pkg::rgb8_t act);
		if (act !== exp)
			stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_board(input string name, input ironhorse_pkg::board_cfg_t exp,
		input ironhorse_pkg::board_cfg_t act);
		if (act !== exp)
			stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_dipsw(input string name, input ironhorse_pkg::dipsw_t exp,
		input ironhorse_pkg::dipsw_t act);
		if (act !== exp)
			stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_pll_write(input string name, input ironhorse_pkg::pll_mgmt_t exp,
		input ironhorse_pkg::pll_mgmt_t act);
		if (act !== exp)
			stop_with_failure($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
	endtask

	// Accepted writes, sampled mid-cycle where port and waitrequest are settled
	always @(negedge CLK_49M) begin
		if (!reset && pll_mgmt.write && !pll_waitrequest)
			pll_seen.push_back(pll_mgmt);
	end

	// ==============================
	// Stimulus
	// ==============================
	task automatic send_key(input logic [7:0] code, input logic pressed);
		@(posedge CLK_49M);
		#1;
		key_event = '{toggle: ~key_event.toggle, pressed: pressed,
		              extended: 1'($random(seed)), code: code};
		kb_ref = kb_after_event(kb_ref, code, pressed);
		// Decoder then mixer
		repeat (2) @(posedge CLK_49M);
		#1;
		check_cabinet("keyboard", expected_cabinet(kb_ref, joy0, joy1, board_ref.is_japan),
		              cabinet);
	endtask

	task automatic send_download(input string name, input logic wr, input logic [7:0] index,
		input logic [24:0] addr, input logic [7:0] data);
		@(posedge CLK_49M);
		#1;
		dl = '{wr: wr, index: index, addr: addr, data: data};
		apply_dl_ref(dl);
		@(posedge CLK_49M);
		#1;
		dl.wr = 1'b0;
		check_board(name, board_ref, board);
		check_dipsw(name, dip_ref, dipsw);
	endtask

	// Random back-pressure until three writes land, then a quiet window
	task automatic wait_pll_sequence(input string name);
		logic bootleg;
		bootleg = (board_ref.is_bootleg == `IH_BOOTLEG_RECONF);
		while (pll_seen.size() < 3) begin
			@(posedge CLK_49M);
			#1;
			pll_waitrequest = 1'($random(seed));
		end
		repeat (10) begin
			@(posedge CLK_49M);
			#1;
			pll_waitrequest = 1'($random(seed));
		end
		if (pll_seen.size() != 3)
			stop_with_failure("PLL sequence did not end after three accepted writes");
		for (int i = 0; i < 3; i++)
			check_pll_write(name, expected_pll_write(i, bootleg, underclock), pll_seen[i]);
		pll_seen.delete();
		pll_waitrequest = 1'b0;
	endtask

	initial begin
		logic [7:0] code;
		logic [7:0] idx;
		logic [7:0] data;
		logic       wr;
		CLK_49M = 1'b0;
		reset = 1'b1;
		key_event = '0;
		joy0 = '0;
		joy1 = '0;
		dl = '0;
		underclock = 1'b0;
		rgb_in = '0;
		pll_waitrequest = 1'b0;
		kb_ref = '0;
		board_ref = '0;
		dip_ref = '0;
		repeat (16) @(posedge CLK_49M);
		#1;
		reset = 1'b0;

		// Reset state
		@(posedge CLK_49M);
		#1;
		check_cabinet("reset", '1, cabinet);
		check_board("reset", '0, board);
		check_dipsw("reset", '0, dipsw);
		check_pll_write("reset", '0, pll_mgmt);
		while (!ce_pix) begin
			@(posedge CLK_49M);
			#1;
		end
		repeat (3) begin
			repeat (7) begin
				@(posedge CLK_49M);
				#1;
				if (ce_pix)
					stop_with_failure("ce_pix came back before 8 cycles had passed");
			end
			@(posedge CLK_49M);
			#1;
			if (!ce_pix)
				stop_with_failure("ce_pix did not return after 8 cycles");
		end

		// Keyboard, one in four codes unknown
		for (int i = 0; i < N_KEY; i++) begin
			if ($random(seed) % 4 == 0)
				code = 8'($random(seed));
			else
				code = KEY_CODES[$unsigned($random(seed)) % 12];
			send_key(code, 1'($random(seed)));
		end
		for (int i = 0; i < 12; i++)
			send_key(KEY_CODES[i], 1'b0);

		// Download stream
		for (int i = 0; i < N_DL; i++) begin
			case ($unsigned($random(seed)) % 3)
				0: idx = `IH_IDX_HEADER;
				1: idx = `IH_IDX_DIP;
				default: idx = 8'($random(seed));
			endcase
			wr = ($random(seed) % 5) != 0;
			code = 8'($unsigned($random(seed)) % 8);
			data = 8'($random(seed));
			// Keep headers off the bootleg code here
			if (idx == `IH_IDX_HEADER)
				data = data & 8'h11;
			send_download("download", wr, idx, 25'(code), data);
		end

		// Joysticks on both board variants
		for (int japan = 0; japan < 2; japan++) begin
			send_download("japan header", 1'b1, `IH_IDX_HEADER, '0, (japan != 0) ? 8'h10 : 8'h00);
			for (int i = 0; i < N_JOY; i++) begin
				@(posedge CLK_49M);
				#1;
				joy0 = 16'($random(seed));
				joy1 = 16'($random(seed));
				@(posedge CLK_49M);
				#1;
				check_cabinet("joystick",
				              expected_cabinet(kb_ref, joy0, joy1, board_ref.is_japan), cabinet);
			end
		end
		joy0 = '0;
		joy1 = '0;

		// Colour
		for (int i = 0; i < N_RGB; i++) begin
			@(posedge CLK_49M);
			#1;
			rgb_in = 12'($random(seed));
			@(posedge CLK_49M);
			#1;
			check_rgb("colour", expected_rgb(rgb_in), rgb_out);
		end

		// PLL reconfiguration
		if (pll_seen.size() != 0)
			stop_with_failure("PLL write issued without an option change");
		for (int i = 0; i < 3; i++) begin
			@(posedge CLK_49M);
			#1;
			underclock = ~underclock;
			wait_pll_sequence("underclock");
		end
		send_download("bootleg header", 1'b1, `IH_IDX_HEADER, '0, {6'b0, `IH_BOOTLEG_RECONF});
		wait_pll_sequence("bootleg");
		@(posedge CLK_49M);
		#1;
		underclock = ~underclock;
		wait_pll_sequence("bootleg underclock");

		if (ironhorse_glue_i.ironhorse_assertions_i.fail_count != 0)
			stop_with_failure("A concurrent assertion failed during the run");
		else begin
			$display("TB PASSED");
			$finish;
		end
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLK_49M);
		stop_with_failure("Watchdog timeout, the tests did not finish in time");
	end

endmodule

// ==== sim.f ====
+incdir+rtl
rtl/ironhorse_pkg.sv
rtl/key_decoder.sv
rtl/control_mixer.sv
rtl/config_loader.sv
rtl/pll_reconfig_seq.sv
rtl/video_color.sv
rtl/ironhorse_glue.sv
sim/ironhorse_assertions.sv
sim/tb_ironhorse_glue.sv

// ==== Bender.yml ====
package:
  name: ironhorse_glue

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/ironhorse_pkg.sv
      - rtl/key_decoder.sv
      - rtl/control_mixer.sv
      - rtl/config_loader.sv
      - rtl/pll_reconfig_seq.sv
      - rtl/video_color.sv
      - rtl/ironhorse_glue.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/ironhorse_assertions.sv
      - sim/tb_ironhorse_glue.sv
